// File: sim/vec_cases.txt
# Columns in hex: op vd vs1 vs2 scalar expected_data expected_err
# op: 0 bcast, 1 add, 2 sub, 3 and, 4 xor, 5 adds, 6 redsum, others illegal
0 1 0 0 50000001 50000001 0
6 0 1 0 00000000 40000004 0
0 2 0 0 00000007 00000007 0
0 3 0 0 0000000c 0000000c 0
1 4 2 3 00000000 00000013 0
6 0 4 0 00000000 0000004c 0
2 5 2 3 00000000 fffffffb 0
6 0 5 0 00000000 ffffffec 0
3 6 2 3 00000000 00000004 0
6 0 6 0 00000000 00000010 0
4 7 2 3 00000000 0000000b 0
6 0 7 0 00000000 0000002c 0
5 4 4 0 00000100 00000113 0
1 4 4 4 00000000 00000226 0
6 0 4 0 00000000 00000898 0
7 1 2 3 deadbeef 00000000 1
6 0 1 0 00000000 40000004 0
f 2 1 1 12345678 00000000 1
6 0 2 0 00000000 0000001c 0
5 0 0 0 12345678 12345678 0
4 0 0 1 00000000 42345679 0
2 3 0 2 00000000 42345672 0
6 0 3 0 00000000 08d159c8 0
0 1 0 0 ffffffff ffffffff 0
6 0 1 0 00000000 fffffffc 0

// File: vec_core.f
common/vec_pkg.sv
dispatcher/vec_dispatcher.sv
rtl/vec_req_queue.sv
lane/vec_lane.sv
lane/vec_exec.sv
rtl/vec_core.sv
sim/vec_core_assertions.sv
sim/tb_vec_core.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_vec_core -f vec_core.f -o tb_vec_core_sim

./obj_dir/tb_vec_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

// File: sim/tb_vec_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_vec_core;

  localparam int unsigned NrLanes    = 4;
  localparam int unsigned QueueDepth = 4;
  localparam int unsigned NrPasses   = 2;
  // Response port held low at the start of the random pass so the queue fills
  localparam int unsigned HoldOff    = 20;

  logic               clk;
  logic               rst_n;
  vec_pkg::acc_req_t  acc_req;
  logic               acc_req_valid;
  logic               acc_req_ready;
  vec_pkg::acc_resp_t acc_resp;
  logic               acc_resp_valid;
  logic               acc_resp_ready;

  vec_pkg::acc_req_t case_req  [$];
  vec_pkg::elem_t    case_data [$];
  logic              case_err  [$];
  string             case_name [$];
  vec_pkg::elem_t    model_vrf [vec_pkg::NrVRegs];

  int unsigned err_cnt     = 0;
  int unsigned resp_cnt    = 0;
  int unsigned stall_cnt   = 0;
  int unsigned cycle_cnt   = 0;
  int unsigned cycle_limit = 100;
  logic        random_mode = 1'b0;

  vec_core #(
    .NrLanes    (NrLanes   ),
    .QueueDepth (QueueDepth)
  ) u_vec_core (
    .clk_i            (clk           ),
    .rst_ni           (rst_n         ),
    .acc_req_i        (acc_req       ),
    .acc_req_valid_i  (acc_req_valid ),
    .acc_req_ready_o  (acc_req_ready ),
    .acc_resp_o       (acc_resp      ),
    .acc_resp_valid_o (acc_resp_valid),
    .acc_resp_ready_i (acc_resp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d responses collected", cycle_cnt, resp_cnt);
      $display("sim failed");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      err_cnt++;
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Every lane sees the same instructions, so one element per register is enough
  task automatic model_step(input vec_pkg::acc_req_t req, output vec_pkg::elem_t data,
                            output logic err);
    vec_pkg::elem_t a;
    vec_pkg::elem_t b;
    a    = model_vrf[req.vs1];
    b    = model_vrf[req.vs2];
    data = '0;
    err  = 1'b0;
    case (req.op)
      vec_pkg::VBCAST:  data = req.scalar;
      vec_pkg::VADD:    data = a + b;
      vec_pkg::VSUB:    data = a - b;
      vec_pkg::VAND:    data = a & b;
      vec_pkg::VXOR:    data = a ^ b;
      vec_pkg::VADDS:   data = a + req.scalar;
      vec_pkg::VREDSUM: begin
        for (int l = 0; l < NrLanes; l++) begin
          data = data + a;
        end
      end
      default:          err = 1'b1;
    endcase
    if (!err && req.op != vec_pkg::VREDSUM) begin
      model_vrf[req.vd] = data;
    end
  endtask

  task automatic load_cases();
    int                fd;
    int                code;
    string             line;
    string             name;
    logic [31:0]       f_op;
    logic [31:0]       f_vd;
    logic [31:0]       f_vs1;
    logic [31:0]       f_vs2;
    logic [31:0]       f_scalar;
    logic [31:0]       f_data;
    logic [31:0]       f_err;
    vec_pkg::acc_req_t req;
    vec_pkg::elem_t    model_data;
    logic              model_err;
    // Registers start at zero after reset
    foreach (model_vrf[r]) begin
      model_vrf[r] = '0;
    end
    fd = $fopen("sim/vec_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the case file sim/vec_cases.txt");
      err_cnt++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_vd, f_vs1, f_vs2,
                              f_scalar, f_data, f_err) == 7) begin
        req.op     = vec_pkg::acc_op_e'(f_op[3:0]);
        req.vd     = f_vd[2:0];
        req.vs1    = f_vs1[2:0];
        req.vs2    = f_vs2[2:0];
        req.scalar = f_scalar;
        name = $sformatf("case%0d_op%0h", case_req.size(), f_op[3:0]);
        case_req.push_back(req);
        case_data.push_back(f_data);
        case_err.push_back(f_err[0]);
        case_name.push_back(name);
        // Cross-check the file against the model before running the DUT
        model_step(req, model_data, model_err);
        check_value({name, "_model"}, f_data, model_data);
        check_value({name, "_model_err"}, 32'(f_err[0]), 32'(model_err));
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////
  // Stimulus and collection
  //////////////////////////////

  task automatic apply_reset();
    @(negedge clk);
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic drive_requests();
    for (int i = 0; i < case_req.size(); i++) begin
      if (random_mode) begin
        repeat ($urandom % 3) @(negedge clk);
      end
      acc_req       = case_req[i];
      acc_req_valid = 1'b1;
      // Ready is registered, so its value here holds through the next rising edge
      while (!acc_req_ready) begin
        stall_cnt++;
        @(negedge clk);
      end
      @(negedge clk);
      acc_req_valid = 1'b0;
    end
  endtask

  task automatic collect_responses();
    int unsigned idx;
    int unsigned cycles;
    idx    = 0;
    cycles = 0;
    while (idx < case_req.size()) begin
      @(negedge clk);
      if (random_mode) begin
        acc_resp_ready = (cycles >= HoldOff) && (($urandom % 4) != 0);
      end
      cycles++;
      // Transfer happens on the next rising edge
      if (acc_resp_valid && acc_resp_ready) begin
        check_value(case_name[idx], case_data[idx], acc_resp.data);
        check_value({case_name[idx], "_err"}, 32'(case_err[idx]), 32'(acc_resp.err));
        idx++;
        resp_cnt++;
      end
    end
  endtask

  initial begin
    void'($urandom(79));
    rst_n          = 1'b0;
    acc_req        = '0;
    acc_req_valid  = 1'b0;
    acc_resp_ready = 1'b0;
    load_cases();
    cycle_limit = 20 * NrPasses * case_req.size() + 100;
    if (case_req.size() == 0) begin
      $display("No instruction cases were loaded");
      err_cnt++;
    end
    // First pass back to back, second pass with random gaps and back-pressure
    for (int p = 0; p < NrPasses; p++) begin
      random_mode = (p != 0);
      apply_reset();
      acc_resp_ready = !random_mode;
      fork
        drive_requests();
        collect_responses();
      join
    end
    if (stall_cnt == 0) begin
      $display("Request port never stalled under back-pressure");
      err_cnt++;
    end
    $display("Errors: %0d, responses: %0d of %0d, request stalls: %0d", err_cnt, resp_cnt,
             NrPasses * case_req.size(), stall_cnt);
    if (err_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/vec_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module vec_core_assertions (
  input logic               clk_i,
  input logic               rst_ni,
  input vec_pkg::acc_resp_t acc_resp_o,
  input logic               acc_resp_valid_o,
  input logic               acc_resp_ready_i
);

  // Response held steady until the core takes it
  property p_resp_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      acc_resp_valid_o && !acc_resp_ready_i |=> acc_resp_valid_o && $stable(acc_resp_o);
  endproperty

  a_resp_stable: assert property (p_resp_stable)
    else $error("Response changed or dropped while waiting for ready");

  a_no_valid_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !acc_resp_valid_o)
    else $error("Response valid high during reset");

  // Illegal requests carry no data
  property p_err_zero_data;
    @(posedge clk_i) disable iff (!rst_ni)
      acc_resp_valid_o && acc_resp_o.err |-> acc_resp_o.data == '0;
  endproperty

  a_err_zero_data: assert property (p_err_zero_data)
    else $error("Error response with nonzero data");

endmodule

bind vec_core vec_core_assertions u_assertions (
  .clk_i            (clk_i           ),
  .rst_ni           (rst_ni          ),
  .acc_resp_o       (acc_resp_o      ),
  .acc_resp_valid_o (acc_resp_valid_o),
  .acc_resp_ready_i (acc_resp_ready_i)
);

`default_nettype wire

// File: rtl/vec_core.sv
`timescale 1ns/100ps
`default_nettype none

module vec_core #(
  parameter int unsigned NrLanes    = 4,
  parameter int unsigned QueueDepth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Request port from the scalar core
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  // Response port to the scalar core
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  vec_pkg::lane_req_t push_req;
  vec_pkg::lane_req_t head_req;
  logic               push;
  logic               pop;
  logic               queue_not_full;
  logic               queue_not_empty;

  //////////////////////////////
  // Decode
  //////////////////////////////

  vec_dispatcher u_dispatcher (
    .acc_req_i       (acc_req_i      ),
    .acc_req_valid_i (acc_req_valid_i),
    .acc_req_ready_o (acc_req_ready_o),
    .queue_ready_i   (queue_not_full ),
    .push_o          (push           ),
    .lane_req_o      (push_req       )
  );

  //////////////////////////////
  // Request queue
  //////////////////////////////

  vec_req_queue #(
    .QueueDepth (QueueDepth)
  ) u_req_queue (
    .clk_i       (clk_i          ),
    .rst_ni      (rst_ni         ),
    .push_i      (push           ),
    .data_i      (push_req       ),
    .pop_i       (pop            ),
    .data_o      (head_req       ),
    .not_full_o  (queue_not_full ),
    .not_empty_o (queue_not_empty)
  );

  //////////////////////////////
  // Lanes and response
  //////////////////////////////

  vec_exec #(
    .NrLanes (NrLanes)
  ) u_exec (
    .clk_i            (clk_i           ),
    .rst_ni           (rst_ni          ),
    .req_i            (head_req        ),
    .req_valid_i      (queue_not_empty ),
    .pop_o            (pop             ),
    .acc_resp_o       (acc_resp_o      ),
    .acc_resp_valid_o (acc_resp_valid_o),
    .acc_resp_ready_i (acc_resp_ready_i)
  );

endmodule

`default_nettype wire

// File: lane/vec_exec.sv
`timescale 1ns/100ps
`default_nettype none

module vec_exec #(
  parameter int unsigned NrLanes = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Head of the request queue
  input  vec_pkg::lane_req_t req_i,
  input  logic               req_valid_i,
  output logic               pop_o,
  // Core response port
  output vec_pkg::acc_resp_t acc_resp_o,
  output logic               acc_resp_valid_o,
  input  logic               acc_resp_ready_i
);

  vec_pkg::elem_t [NrLanes-1:0] lane_result;
  vec_pkg::elem_t [NrLanes-1:0] lane_vs1;
  vec_pkg::elem_t               red_sum;
  vec_pkg::acc_resp_t           resp_d;
  vec_pkg::acc_resp_t           resp_q;
  logic                         resp_valid_q;

  //////////////////////////////
  // Issue
  //////////////////////////////

  // Response slot free now or emptied by a transfer this cycle
  assign pop_o = req_valid_i & (~resp_valid_q | acc_resp_ready_i);

  //////////////////////////////
  // Lanes
  //////////////////////////////

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lanes
    vec_lane u_lane (
      .clk_i      (clk_i         ),
      .rst_ni     (rst_ni        ),
      .exec_i     (pop_o         ),
      .req_i      (req_i         ),
      .result_o   (lane_result[l]),
      .vs1_elem_o (lane_vs1[l]   )
    );
  end : gen_lanes

  // Cross-lane sum, wraps at element width
  always_comb begin
    red_sum = '0;
    for (int l = 0; l < NrLanes; l++) begin
      red_sum = red_sum + lane_vs1[l];
    end
  end

  //////////////////////////////
  // Response register
  //////////////////////////////

  always_comb begin
    resp_d.err  = 1'b0;
    resp_d.data = lane_result[0];
    if (req_i.illegal) begin
      resp_d.err  = 1'b1;
      resp_d.data = '0;
    end else if (req_i.reduce) begin
      resp_d.data = red_sum;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      resp_q       <= '0;
    end else if (pop_o) begin
      resp_valid_q <= 1'b1;
      resp_q       <= resp_d;
    end else if (acc_resp_ready_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  assign acc_resp_o       = resp_q;
  assign acc_resp_valid_o = resp_valid_q;

endmodule

`default_nettype wire

// File: lane/vec_lane.sv
`timescale 1ns/100ps
`default_nettype none

module vec_lane (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               exec_i,
  input  vec_pkg::lane_req_t req_i,
  output vec_pkg::elem_t     result_o,
  output vec_pkg::elem_t     vs1_elem_o
);

  // This lane's element of every vector register
  vec_pkg::elem_t vrf_q [vec_pkg::NrVRegs];

  vec_pkg::elem_t opa;
  vec_pkg::elem_t opb;

  //////////////////////////////
  // Operand read
  //////////////////////////////

  assign opa        = vrf_q[req_i.vs1];
  assign opb        = req_i.use_scalar ? req_i.scalar : vrf_q[req_i.vs2];
  assign vs1_elem_o = opa;

  //////////////////////////////
  // Element ALU
  //////////////////////////////

  always_comb begin
    case (req_i.alu_op)
      vec_pkg::ADD:    result_o = opa + opb;
      vec_pkg::SUB:    result_o = opa - opb;
      vec_pkg::AND:    result_o = opa & opb;
      vec_pkg::XOR:    result_o = opa ^ opb;
      default:         result_o = opb;
    endcase
  end

  //////////////////////////////
  // Register write
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int r = 0; r < vec_pkg::NrVRegs; r++) begin
        vrf_q[r] <= '0;
      end
    end else if (exec_i && req_i.write_en) begin
      vrf_q[req_i.vd] <= result_o;
    end
  end

endmodule

`default_nettype wire

// File: rtl/vec_req_queue.sv
`timescale 1ns/100ps
`default_nettype none

module vec_req_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               push_i,
  input  vec_pkg::lane_req_t data_i,
  input  logic               pop_i,
  output vec_pkg::lane_req_t data_o,
  output logic               not_full_o,
  output logic               not_empty_o
);

  localparam int unsigned PtrWidth = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(QueueDepth + 1);

  typedef logic [PtrWidth-1:0] ptr_t;
  typedef logic [CntWidth-1:0] cnt_t;

  vec_pkg::lane_req_t mem_q [QueueDepth];
  ptr_t               wr_ptr_q;
  ptr_t               rd_ptr_q;
  cnt_t               count_q;
  logic               do_push;
  logic               do_pop;

  assign not_full_o  = (count_q != cnt_t'(QueueDepth));
  assign not_empty_o = (count_q != '0);

  // A pop in the same cycle frees the slot for a push into a full queue
  assign do_pop  = pop_i & not_empty_o;
  assign do_push = push_i & (not_full_o | do_pop);

  assign data_o = mem_q[rd_ptr_q];

  //////////////////////////////
  // Pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(QueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(QueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: dispatcher/vec_dispatcher.sv
`timescale 1ns/100ps
`default_nettype none

module vec_dispatcher (
  // Core request port
  input  vec_pkg::acc_req_t  acc_req_i,
  input  logic               acc_req_valid_i,
  output logic               acc_req_ready_o,
  // Request queue
  input  logic               queue_ready_i,
  output logic               push_o,
  output vec_pkg::lane_req_t lane_req_o
);

  //////////////////////////////
  // Handshake
  //////////////////////////////

  assign acc_req_ready_o = queue_ready_i;
  assign push_o          = acc_req_valid_i & queue_ready_i;

  //////////////////////////////
  // Decode
  //////////////////////////////

  always_comb begin
    // Register fields and scalar pass straight through
    lane_req_o            = '0;
    lane_req_o.vd         = acc_req_i.vd;
    lane_req_o.vs1        = acc_req_i.vs1;
    lane_req_o.vs2        = acc_req_i.vs2;
    lane_req_o.scalar     = acc_req_i.scalar;
    lane_req_o.alu_op     = vec_pkg::PASS_B;
    lane_req_o.write_en   = 1'b1;

    case (acc_req_i.op)
      vec_pkg::VBCAST: begin
        lane_req_o.use_scalar = 1'b1;
      end
      vec_pkg::VADD: lane_req_o.alu_op = vec_pkg::ADD;
      vec_pkg::VSUB: lane_req_o.alu_op = vec_pkg::SUB;
      vec_pkg::VAND: lane_req_o.alu_op = vec_pkg::AND;
      vec_pkg::VXOR: lane_req_o.alu_op = vec_pkg::XOR;
      vec_pkg::VADDS: begin
        lane_req_o.alu_op     = vec_pkg::ADD;
        lane_req_o.use_scalar = 1'b1;
      end
      vec_pkg::VREDSUM: begin
        // Sum of vs1 across lanes, nothing written
        lane_req_o.write_en = 1'b0;
        lane_req_o.reduce   = 1'b1;
      end
      default: begin
        lane_req_o.write_en = 1'b0;
        lane_req_o.illegal  = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: common/vec_pkg.sv
`default_nettype none

package vec_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int unsigned ElemWidth = 32;
  localparam int unsigned NrVRegs   = 8;

  typedef logic [ElemWidth-1:0]       elem_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_idx_t;

  //////////////////////////////
  // Opcodes
  //////////////////////////////

  // Core opcodes, encodings 7 to 15 are illegal
  typedef enum logic [3:0] {
    VBCAST  = 4'd0,
    VADD    = 4'd1,
    VSUB    = 4'd2,
    VAND    = 4'd3,
    VXOR    = 4'd4,
    VADDS   = 4'd5,
    VREDSUM = 4'd6
  } acc_op_e;

  // Element ALU operation
  typedef enum logic [2:0] {
    PASS_B = 3'd0,
    ADD    = 3'd1,
    SUB    = 3'd2,
    AND    = 3'd3,
    XOR    = 3'd4
  } alu_op_e;

  //////////////////////////////
  // Requests and responses
  //////////////////////////////

  // Request from the scalar core
  typedef struct packed {
    acc_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } acc_req_t;

  // Decoded request as seen by every lane
  typedef struct packed {
    alu_op_e   alu_op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    logic      use_scalar;  // Operand B comes from scalar
    logic      write_en;
    logic      reduce;
    logic      illegal;
    elem_t     scalar;
  } lane_req_t;

  // Response toward the scalar core
  typedef struct packed {
    elem_t data;
    logic  err;
  } acc_resp_t;

endpackage

`default_nettype wire
